// ==== verilog.f ====
src/dw_pkg.sv
src/dw_line_ram.sv
src/dw_row_buf.sv
src/dw_window.sv
src/dw_weight_bank.sv
src/dw_mac.sv
src/dw_conv_top.sv
bench/dw_conv_tb.sv

// ==== Bender.yml ====
package:
  name: dw_conv

sources:
  - src/dw_pkg.sv
  - src/dw_line_ram.sv
  - src/dw_row_buf.sv
  - src/dw_window.sv
  - src/dw_weight_bank.sv
  - src/dw_mac.sv
  - src/dw_conv_top.sv
  - target: test
    files:
      - bench/dw_conv_tb.sv

// ==== bench/dw_conv_tb.sv ====
`timescale 1ns/1ps

module dw_conv_tb;

    localparam int CH          = 4;
    localparam int MAX_ROW_LEN = 64;
    localparam int LW          = $clog2(MAX_ROW_LEN + 1);

    logic          clk = 1'b0;
    logic          rstn;
    dw_pkg::pix_t  pix_in;
    logic          in_valid;
    logic          in_ready;
    dw_pkg::res_t  res_out;
    logic          out_valid;
    logic          out_ready;
    logic [LW-1:0] row_len;
    logic          row_len_load;
    dw_pkg::wcfg_t wcfg;

    dw_pkg::pix_t  img [8][8];                  // model image, row then column
    int            wt [CH][9];                  // model weights, row-major taps
    dw_pkg::res_t  exp_q [$];
    int            row_q [$];
    int            col_q [$];
    int            err_cnt = 0;
    int            tmo_cnt = 0;
    int            got_cnt = 0;
    int            cyc = 0;                     // rising edges seen so far
    int            lat_mark = -1;               // cycle the timed pixel was driven
    bit            bp_mode = 1'b0;
    bit            held_ok = 1'b0;
    dw_pkg::res_t  held;

    dw_conv_top #(.CH(CH), .MAX_ROW_LEN(MAX_ROW_LEN)) dw_conv_top_inst (
        .clk          (clk),
        .rstn         (rstn),
        .pix_in       (pix_in),
        .in_valid     (in_valid),
        .in_ready     (in_ready),
        .res_out      (res_out),
        .out_valid    (out_valid),
        .out_ready    (out_ready),
        .row_len      (row_len),
        .row_len_load (row_len_load),
        .wcfg         (wcfg)
    );

    always #5 clk = ~clk;

    // sum over the 3x3 window ending at (r, c), per channel
    function automatic dw_pkg::res_t ref_conv(input int r, input int c);
        dw_pkg::res_t res;
        int           acc;
        res = '0;
        for (int ch = 0; ch < CH; ch++) begin
            acc = 0;
            for (int i = 0; i < 3; i++) begin
                for (int j = 0; j < 3; j++) begin
                    acc += int'($signed(img[r-2+i][c-2+j].smp[ch])) * wt[ch][i*3+j];
                end
            end
            res.acc[ch] = acc[dw_pkg::ACC_W-1:0];
        end
        return res;
    endfunction

    task automatic write_weight(input int ch, input dw_pkg::tap_e tap, input logic [7:0] coef);
        wcfg.ch   = 3'(ch);
        wcfg.tap  = tap;
        wcfg.coef = coef;
        wcfg.we   = 1'b1;
        @(negedge clk);
        wcfg.we   = 1'b0;
    endtask

    task automatic load_weights;
        logic [7:0] rb;
        for (int ch = 0; ch < CH; ch++) begin
            for (int t = 0; t < 9; t++) begin
                rb        = 8'($urandom);
                wt[ch][t] = int'($signed(rb));
                write_weight(ch, dw_pkg::tap_e'(t), rb);
            end
        end
        @(negedge clk);
    endtask

    task automatic send_pixel(input dw_pkg::pix_t p, input int gap, input bit mark);
        int wait_cnt;
        in_valid = 1'b0;
        repeat (gap) @(negedge clk);
        pix_in   = p;
        in_valid = 1'b1;
        if (mark) begin
            lat_mark = cyc;
        end
        wait_cnt = 0;
        @(posedge clk);
        while (!in_ready && wait_cnt < 100) begin
            wait_cnt++;
            @(posedge clk);
        end
        if (!in_ready) begin
            tmo_cnt++;
            $display("timeout: the DUT stopped accepting pixels at %0t", $time);
        end
        @(negedge clk);
    endtask

    task automatic wait_drain(input int expected);
        int wait_cnt;
        wait_cnt = 0;
        while (exp_q.size() != 0 && wait_cnt < 500) begin
            wait_cnt++;
            @(negedge clk);
        end
        if (exp_q.size() != 0) begin
            tmo_cnt++;
            $display("timeout: %0d expected results never came out", exp_q.size());
        end
        repeat (8) @(negedge clk);              // room for any extra result
        if (got_cnt != expected) begin
            err_cnt++;
            $display("error at %0t: got %0d results, expected %0d", $time, got_cnt, expected);
        end
    endtask

    task automatic run_frame(input int rows, input int cols, input bit fresh,
                             input bit gaps, input bit mark);
        int n;
        int gap;
        if (tmo_cnt != 0) begin
            return;
        end
        if (fresh) begin
            for (int r = 0; r < rows; r++) begin
                for (int c = 0; c < cols; c++) begin
                    img[r][c] = {$urandom, $urandom};   // spare lanes random too
                end
            end
        end
        n = 0;
        for (int r = 2; r < rows; r++) begin
            for (int c = 2; c < cols; c++) begin
                exp_q.push_back(ref_conv(r, c));
                row_q.push_back(r);
                col_q.push_back(c);
                n++;
            end
        end
        got_cnt      = 0;
        row_len      = LW'(cols);
        row_len_load = 1'b1;                    // rows start afresh
        @(negedge clk);
        row_len_load = 1'b0;
        for (int r = 0; r < rows && tmo_cnt == 0; r++) begin
            for (int c = 0; c < cols && tmo_cnt == 0; c++) begin
                gap = 0;
                if (gaps && ($urandom % 4 == 0)) begin
                    gap = 1 + $urandom % 3;
                end
                send_pixel(img[r][c], gap, mark && r == 2 && c == 2);
            end
        end
        in_valid = 1'b0;
        wait_drain(n);
    endtask

    task automatic check_output;
        dw_pkg::res_t exp;
        int           r;
        int           c;
        got_cnt++;
        if (exp_q.size() == 0) begin
            err_cnt++;
            $display("error at %0t: result came out with nothing expected", $time);
        end else begin
            exp = exp_q.pop_front();
            r   = row_q.pop_front();
            c   = col_q.pop_front();
            for (int l = 0; l < dw_pkg::CH_MAX; l++) begin
                if (res_out.acc[l] != exp.acc[l]) begin
                    err_cnt++;
                    $display("error at %0t: row %0d col %0d ch %0d got %0d expected %0d",
                             $time, r, c, l, $signed(res_out.acc[l]), $signed(exp.acc[l]));
                end
            end
        end
    endtask

    // compares on pre-edge values, outputs are settled here
    always @(posedge clk) begin
        if (rstn) begin
            if (lat_mark >= 0 && out_valid) begin
                if (cyc - lat_mark != 3) begin
                    err_cnt++;
                    $display("error at %0t: latency %0d cycles, expected 3", $time,
                             cyc - lat_mark);
                end
                lat_mark = -1;
            end
            if (out_valid && !out_ready && in_ready) begin
                err_cnt++;
                $display("error at %0t: in_ready high while the output is stalled", $time);
            end
            if (held_ok && out_valid && res_out != held) begin
                err_cnt++;
                $display("error at %0t: res_out changed during a stall", $time);
            end
            held_ok = out_valid && !out_ready;
            held    = res_out;
            if (out_valid && out_ready) begin
                check_output();
            end
        end
        cyc++;
    end

    always @(negedge clk) begin
        if (bp_mode) begin
            out_ready = ($urandom % 3 != 0);
        end
    end

    initial begin
        void'($urandom(34881));
        rstn         = 1'b0;
        pix_in       = '0;
        in_valid     = 1'b0;
        out_ready    = 1'b1;
        row_len      = LW'(8);
        row_len_load = 1'b0;
        wcfg         = '0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rstn = 1'b1;
        @(negedge clk);

        if (out_valid !== 1'b0 || in_ready !== 1'b1) begin
            err_cnt++;
            $display("error at %0t: wrong state after reset", $time);
        end

        load_weights();
        run_frame(6, 8, 1'b1, 1'b0, 1'b1);      // basic frame plus latency
        if (lat_mark != -1) begin
            err_cnt++;
            $display("error at %0t: out_valid never rose for the timed pixel", $time);
            lat_mark = -1;
        end

        bp_mode = 1'b1;
        run_frame(6, 8, 1'b0, 1'b1, 1'b0);      // same frame, random stalls
        bp_mode   = 1'b0;
        out_ready = 1'b1;

        run_frame(5, 5, 1'b1, 1'b0, 1'b0);

        write_weight(CH, dw_pkg::t11, 8'h7f);   // lane not built, dropped
        @(negedge clk);
        run_frame(5, 5, 1'b1, 1'b1, 1'b0);

        $display("errors: %0d, timeouts: %0d", err_cnt, tmo_cnt);
        if (err_cnt == 0 && tmo_cnt == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// ==== src/dw_conv_top.sv ====
`timescale 1ns/1ps

module dw_conv_top #(
    parameter int CH          = 4,
    parameter int MAX_ROW_LEN = 64
) (
    input  logic                             clk,
    input  logic                             rstn,
    input  dw_pkg::pix_t                     pix_in,
    input  logic                             in_valid,
    output logic                             in_ready,
    output dw_pkg::res_t                     res_out,
    output logic                             out_valid,
    input  logic                             out_ready,
    input  logic [$clog2(MAX_ROW_LEN+1)-1:0] row_len,
    input  logic                             row_len_load,
    input  dw_pkg::wcfg_t                    wcfg
);

    logic                                   advance;
    dw_pkg::col_t                           col;
    logic                                   col_valid;
    logic                                   row_ok;
    dw_pkg::win_t                           win;
    logic                                   win_valid;
    logic [CH-1:0][8:0][dw_pkg::COEF_W-1:0] coefs;

    // whole pipeline steps together, stalls only on a full output slot
    assign advance  = ~out_valid | out_ready;
    assign in_ready = advance;

    dw_row_buf #(.MAX_ROW_LEN(MAX_ROW_LEN)) dw_row_buf_inst (
        .clk          (clk),
        .rstn         (rstn),
        .advance      (advance),
        .pix_in       (pix_in),
        .in_valid     (in_valid),
        .row_len      (row_len),
        .row_len_load (row_len_load),
        .col          (col),
        .col_valid    (col_valid),
        .row_ok       (row_ok)
    );

    dw_window #(.MAX_ROW_LEN(MAX_ROW_LEN)) dw_window_inst (
        .clk          (clk),
        .rstn         (rstn),
        .advance      (advance),
        .col          (col),
        .col_valid    (col_valid),
        .row_ok       (row_ok),
        .row_len      (row_len),
        .row_len_load (row_len_load),
        .win          (win),
        .win_valid    (win_valid)
    );

    dw_weight_bank #(.CH(CH)) dw_weight_bank_inst (
        .clk   (clk),
        .rstn  (rstn),
        .wcfg  (wcfg),
        .coefs (coefs)
    );

    dw_mac #(.CH(CH)) dw_mac_inst (
        .clk       (clk),
        .rstn      (rstn),
        .advance   (advance),
        .win       (win),
        .win_valid (win_valid),
        .coefs     (coefs),
        .res_out   (res_out),
        .out_valid (out_valid)
    );

endmodule

// ==== src/dw_mac.sv ====
`timescale 1ns/1ps

module dw_mac #(
    parameter int CH = 4
) (
    input  logic                                   clk,
    input  logic                                   rstn,
    input  logic                                   advance,
    input  dw_pkg::win_t                           win,
    input  logic                                   win_valid,
    input  logic [CH-1:0][8:0][dw_pkg::COEF_W-1:0] coefs,
    output dw_pkg::res_t                           res_out,
    output logic                                   out_valid
);

    localparam int PW = 2 * dw_pkg::DATA_W;     // product width

    dw_pkg::pix_t           taps [9];
    logic [CH-1:0][8:0][PW-1:0] prod_d;
    logic [CH-1:0][8:0][PW-1:0] prod_q;
    dw_pkg::res_t           sum_d;
    dw_pkg::res_t           sum_q;
    dw_pkg::mac_state_e     mult_state_q;
    dw_pkg::mac_state_e     sum_state_q;
    logic                   mult_valid;
    logic                   sum_valid;

    // window in tap order, row-major with oldest row and column first
    always_comb begin
        taps[0] = win.left.top;
        taps[1] = win.centre.top;
        taps[2] = win.right.top;
        taps[3] = win.left.mid;
        taps[4] = win.centre.mid;
        taps[5] = win.right.mid;
        taps[6] = win.left.bot;
        taps[7] = win.centre.bot;
        taps[8] = win.right.bot;
    end

    always_comb begin
        for (int c = 0; c < CH; c++) begin
            for (int t = 0; t < 9; t++) begin
                prod_d[c][t] = $signed(taps[t].smp[c]) * $signed(coefs[c][t]);
            end
        end
    end

    // adder tree over the nine registered products
    always_comb begin
        logic signed [dw_pkg::ACC_W-1:0] acc;
        sum_d = '0;                             // unused lanes stay zero
        for (int c = 0; c < CH; c++) begin
            acc = '0;
            for (int t = 0; t < 9; t++) begin
                acc = acc + $signed(prod_q[c][t]);
            end
            sum_d.acc[c] = acc;
        end
    end

    // slot tags, the valid bits are decoded from them
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            mult_state_q <= dw_pkg::mac_idle;
            sum_state_q  <= dw_pkg::mac_idle;
        end else if (advance) begin
            mult_state_q <= win_valid  ? dw_pkg::mac_mult : dw_pkg::mac_idle;
            sum_state_q  <= mult_valid ? dw_pkg::mac_sum  : dw_pkg::mac_idle;
        end
    end

    assign mult_valid = (mult_state_q == dw_pkg::mac_mult);
    assign sum_valid  = (sum_state_q == dw_pkg::mac_sum);

    always_ff @(posedge clk) begin
        if (advance) begin
            if (win_valid) begin
                prod_q <= prod_d;               // stage 1
            end
            if (mult_valid) begin
                sum_q <= sum_d;                 // stage 2
            end
        end
    end

    assign res_out   = sum_q;
    assign out_valid = sum_valid;

endmodule

// ==== src/dw_weight_bank.sv ====
`timescale 1ns/1ps

module dw_weight_bank #(
    parameter int CH = 4
) (
    input  logic                                 clk,
    input  logic                                 rstn,
    input  dw_pkg::wcfg_t                        wcfg,
    output logic [CH-1:0][8:0][dw_pkg::COEF_W-1:0] coefs
);

    dw_pkg::tap_e wtap;
    logic         ch_ok;
    logic         tap_ok;
    logic         wr_ok;

    assign wtap   = dw_pkg::tap_e'(wcfg.tap);
    assign ch_ok  = (int'(wcfg.ch) < CH);       // lanes above CH are not built
    assign tap_ok = (wtap <= dw_pkg::t22);
    assign wr_ok  = wcfg.we & ch_ok & tap_ok;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            coefs <= '0;
        end else if (wr_ok) begin
            coefs[wcfg.ch][wcfg.tap] <= wcfg.coef;  // visible next cycle
        end
    end

endmodule

// ==== src/dw_window.sv ====
`timescale 1ns/1ps

module dw_window #(
    parameter int MAX_ROW_LEN = 64
) (
    input  logic                             clk,
    input  logic                             rstn,
    input  logic                             advance,
    input  dw_pkg::col_t                     col,
    input  logic                             col_valid,
    input  logic                             row_ok,
    input  logic [$clog2(MAX_ROW_LEN+1)-1:0] row_len,
    input  logic                             row_len_load,
    output dw_pkg::win_t                     win,
    output logic                             win_valid
);

    localparam int LW = $clog2(MAX_ROW_LEN + 1);

    logic          shift;
    logic [LW-1:0] col_cnt_q;                   // index of the presented column
    logic [LW-1:0] col_cnt_d;
    logic          col_ge2_q;                   // presented column is 2 or later
    dw_pkg::col_t  left_q;
    dw_pkg::col_t  centre_q;

    assign shift = advance & col_valid;

    always_comb begin
        if (col_cnt_q == row_len - LW'(1)) begin
            col_cnt_d = '0;                     // next column starts a new row
        end else begin
            col_cnt_d = col_cnt_q + LW'(1);
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            col_cnt_q <= '0;
            col_ge2_q <= 1'b0;
        end else if (row_len_load) begin
            col_cnt_q <= '0;
            col_ge2_q <= 1'b0;
        end else if (shift) begin
            col_cnt_q <= col_cnt_d;
            col_ge2_q <= (col_cnt_d >= LW'(2));
        end
    end

    always_ff @(posedge clk) begin
        if (shift) begin
            left_q   <= centre_q;
            centre_q <= col;
        end
    end

    // newest column comes straight from the row buffer register
    assign win.left   = left_q;
    assign win.centre = centre_q;
    assign win.right  = col;

    // windows that straddle a row edge are dropped here
    assign win_valid = col_valid & row_ok & col_ge2_q;

endmodule

// ==== src/dw_row_buf.sv ====
`timescale 1ns/1ps

module dw_row_buf #(
    parameter int MAX_ROW_LEN = 64
) (
    input  logic                             clk,
    input  logic                             rstn,
    input  logic                             advance,
    input  dw_pkg::pix_t                     pix_in,
    input  logic                             in_valid,
    input  logic [$clog2(MAX_ROW_LEN+1)-1:0] row_len,
    input  logic                             row_len_load,
    output dw_pkg::col_t                     col,
    output logic                             col_valid,
    output logic                             row_ok
);

    localparam int AW = $clog2(MAX_ROW_LEN);
    localparam int LW = $clog2(MAX_ROW_LEN + 1);

    logic          accept;
    logic          last_col;
    logic [AW-1:0] addr_q;                      // column of the next pixel
    logic [AW-1:0] wr2_addr_q;                  // row2 is written one accept behind
    logic [1:0]    row_cnt_q;                   // saturates at 2
    logic          col_valid_q;
    logic          row_ok_q;
    dw_pkg::pix_t  cur_q;
    dw_pkg::pix_t  row1_rd;
    dw_pkg::pix_t  row2_rd;

    assign accept   = advance & in_valid;
    assign last_col = (LW'(addr_q) == row_len - LW'(1));

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            addr_q    <= '0;
            row_cnt_q <= '0;
        end else if (row_len_load) begin
            addr_q    <= '0;                    // old rows are stale now
            row_cnt_q <= '0;
        end else if (accept) begin
            if (last_col) begin
                addr_q <= '0;
                if (row_cnt_q != 2'd2) begin
                    row_cnt_q <= row_cnt_q + 2'd1;
                end
            end else begin
                addr_q <= addr_q + 1'b1;
            end
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            col_valid_q <= 1'b0;
            row_ok_q    <= 1'b0;
        end else if (row_len_load) begin
            col_valid_q <= 1'b0;
            row_ok_q    <= 1'b0;
        end else if (advance) begin
            col_valid_q <= in_valid;            // bubble when no pixel
            if (in_valid) begin
                row_ok_q <= (row_cnt_q == 2'd2);    // row of this pixel
            end
        end
    end

    // current pixel lines up with the ram outputs
    always_ff @(posedge clk) begin
        if (accept) begin
            cur_q      <= pix_in;
            wr2_addr_q <= addr_q;
        end
    end

    dw_line_ram #(.MAX_ROW_LEN(MAX_ROW_LEN)) row1_ram (
        .clk     (clk),
        .wr_en   (accept),
        .wr_addr (addr_q),
        .wr_data (pix_in),
        .rd_en   (accept),
        .rd_addr (addr_q),
        .rd_data (row1_rd)
    );

    // cascade: previous row word read from row1 moves down to row2
    dw_line_ram #(.MAX_ROW_LEN(MAX_ROW_LEN)) row2_ram (
        .clk     (clk),
        .wr_en   (accept),
        .wr_addr (wr2_addr_q),
        .wr_data (row1_rd),
        .rd_en   (accept),
        .rd_addr (addr_q),
        .rd_data (row2_rd)
    );

    assign col.top   = row2_rd;
    assign col.mid   = row1_rd;
    assign col.bot   = cur_q;
    assign col_valid = col_valid_q;
    assign row_ok    = row_ok_q;

endmodule

// ==== src/dw_line_ram.sv ====
`timescale 1ns/1ps

module dw_line_ram #(
    parameter int MAX_ROW_LEN = 64
) (
    input  logic                           clk,
    input  logic                           wr_en,
    input  logic [$clog2(MAX_ROW_LEN)-1:0] wr_addr,
    input  dw_pkg::pix_t                   wr_data,
    input  logic                           rd_en,
    input  logic [$clog2(MAX_ROW_LEN)-1:0] rd_addr,
    output dw_pkg::pix_t                   rd_data
);

    dw_pkg::pix_t mem [MAX_ROW_LEN];            // one row of pixels

    // write port
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // registered read, old word on an address clash
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= mem[rd_addr];            // holds while rd_en is low
        end
    end

endmodule

// ==== src/dw_pkg.sv ====
package dw_pkg;

    localparam int DATA_W = 8;                  // signed channel sample
    localparam int COEF_W = 8;                  // signed weight
    localparam int ACC_W  = 20;                 // nine 16 bit products
    localparam int CH_MAX = 8;                  // lanes held by the structs

    // one pixel, all channels side by side, lane 0 in the low bits
    typedef struct packed {
        logic [CH_MAX-1:0][DATA_W-1:0] smp;
    } pix_t;

    // vertical column, oldest row first
    typedef struct packed {
        pix_t top;                              // two rows back
        pix_t mid;                              // one row back
        pix_t bot;                              // current row
    } col_t;

    // 3x3 window, oldest column first
    typedef struct packed {
        col_t left;
        col_t centre;
        col_t right;
    } win_t;

    typedef struct packed {
        logic [CH_MAX-1:0][ACC_W-1:0] acc;      // signed per-channel sums
    } res_t;

    typedef struct packed {
        logic [2:0]        ch;                  // channel lane
        logic [3:0]        tap;                 // row-major, 0 to 8
        logic [COEF_W-1:0] coef;                // signed weight
        logic              we;
    } wcfg_t;

    // tap index is row * 3 + column
    typedef enum logic [3:0] {
        t00 = 4'd0, t01 = 4'd1, t02 = 4'd2,
        t10 = 4'd3, t11 = 4'd4, t12 = 4'd5,
        t20 = 4'd6, t21 = 4'd7, t22 = 4'd8
    } tap_e;

    // occupancy tag of one mac pipeline slot
    typedef enum logic [1:0] {
        mac_idle = 2'd0,
        mac_mult = 2'd1,
        mac_sum  = 2'd2
    } mac_state_e;

endpackage
